// File: logic/rvcPkg.sv
`default_nettype none

package rvcPkg;

  localparam int unsigned xlen     = 32;
  localparam int unsigned parcelW  = 16;
  localparam int unsigned regW     = 5;  // Full register index
  localparam int unsigned cRegW    = 3;  // Compressed register index x8..x15
  localparam int unsigned funct3W  = 3;
  localparam int unsigned opcodeW  = 7;

  typedef enum logic [1:0] {
    qdZero = 2'b00,
    qdOne  = 2'b01,
    qdTwo  = 2'b10,
    qdFull = 2'b11  // Not compressed
  } rvcQuadrant;

  typedef enum logic [1:0] {
    esExpanded,
    esFull,
    esIllegal,
    esUnsupported
  } expandStatus;

  // Base opcodes produced by the expander
  typedef enum logic [opcodeW-1:0] {
    opLoad   = 7'b0000011,
    opOpImm  = 7'b0010011,
    opStore  = 7'b0100011,
    opOp     = 7'b0110011,
    opLui    = 7'b0110111,
    opBranch = 7'b1100011
  } rvOpcode;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] raw;           // Upper half zero when compressed
    logic            isCompressed;
  } fetchBundle;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
    expandStatus     status;
  } expandedInstr;

endpackage

`default_nettype wire

// File: logic/parcelAssembler.sv
`timescale 1ns/1ps
`default_nettype none

module parcelAssembler #(
  parameter logic [rvcPkg::xlen-1:0] resetPc = '0
) (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       parcelReq,
  input  logic [rvcPkg::parcelW-1:0] parcelData,
  output logic                       parcelAck,
  output logic                       push,
  output rvcPkg::fetchBundle         pushBundle,
  input  logic                       full
);
  import rvcPkg::*;

  typedef enum logic {
    fsIdle,
    fsAckHold
  } fetchState;

  fetchState          state;
  logic [xlen-1:0]    pcReg;    // pc of the next instruction
  logic [parcelW-1:0] lowHalf;
  logic               halfValid;
  logic               accept;
  logic               startsFull;

  assign accept     = (state == fsIdle) && parcelReq && !full;
  assign startsFull = rvcQuadrant'(parcelData[1:0]) == qdFull;
  assign push       = accept && (halfValid || !startsFull);
  assign parcelAck  = (state == fsAckHold);

  // Bundle carries the pc of its first parcel
  always_comb begin
    pushBundle.pc = pcReg;
    if (halfValid) begin
      pushBundle.raw          = {parcelData, lowHalf};
      pushBundle.isCompressed = 1'b0;
    end else begin
      pushBundle.raw          = {{(xlen - parcelW){1'b0}}, parcelData};
      pushBundle.isCompressed = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= fsIdle;
    end else begin
      case (state)
        fsIdle: begin
          if (accept) begin
            state <= fsAckHold;
          end
        end
        fsAckHold: begin
          if (!parcelReq) begin
            state <= fsIdle;  // Four-phase return to zero
          end
        end
        default: state <= fsIdle;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcReg     <= resetPc;
      halfValid <= 1'b0;
    end else if (accept) begin
      if (halfValid) begin
        halfValid <= 1'b0;
        pcReg     <= pcReg + xlen'(4);
      end else if (startsFull) begin
        halfValid <= 1'b1;  // Wait for upper half
      end else begin
        pcReg     <= pcReg + xlen'(2);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !halfValid) begin
      lowHalf <= parcelData;
    end
  end

endmodule

`default_nettype wire

// File: logic/fetchQueue.sv
`timescale 1ns/1ps
`default_nettype none

module fetchQueue #(
  parameter int unsigned queueDepth = 4
) (
  input  logic               clk,
  input  logic               rstN,
  input  logic               push,
  input  rvcPkg::fetchBundle pushBundle,
  output logic               full,
  input  logic               pop,
  output rvcPkg::fetchBundle headBundle,
  output logic               empty
);
  import rvcPkg::*;

  localparam int unsigned addrW = $clog2(queueDepth);

  fetchBundle       mem [queueDepth];
  logic [addrW:0]   wrPtr;  // Extra bit marks wrap
  logic [addrW:0]   rdPtr;

  assign empty      = (wrPtr == rdPtr);
  assign full       = (wrPtr[addrW] != rdPtr[addrW]) &&
                      (wrPtr[addrW-1:0] == rdPtr[addrW-1:0]);
  assign headBundle = mem[rdPtr[addrW-1:0]];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (push) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr[addrW-1:0]] <= pushBundle;
    end
  end

endmodule

`default_nettype wire

// File: logic/rvcExpander.sv
`timescale 1ns/1ps
`default_nettype none

module rvcExpander (
  input  rvcPkg::fetchBundle        bundle,
  output logic [rvcPkg::xlen-1:0]   instr,
  output rvcPkg::expandStatus       status
);
  import rvcPkg::*;

  logic [parcelW-1:0] cInst;
  rvcQuadrant         quad;
  logic [funct3W-1:0] funct3;
  logic [regW-1:0]    rdFull;     // Bits 11:7
  logic [regW-1:0]    rs2Full;    // Bits 6:2
  logic [cRegW-1:0]   rs1Short;
  logic [cRegW-1:0]   rs2Short;
  logic [regW-1:0]    rs1Prime;
  logic [regW-1:0]    rs2Prime;
  logic [11:0]        immSpn;
  logic [11:0]        immMem;
  logic [11:0]        immCi;
  logic [19:0]        immLui;
  logic [12:0]        immB;

  assign cInst    = bundle.raw[parcelW-1:0];
  assign quad     = rvcQuadrant'(cInst[1:0]);
  assign funct3   = cInst[15:13];
  assign rdFull   = cInst[11:7];
  assign rs2Full  = cInst[6:2];
  assign rs1Short = cInst[9:7];
  assign rs2Short = cInst[4:2];
  assign rs1Prime = {2'b01, rs1Short};
  assign rs2Prime = {2'b01, rs2Short};

  // Scrambled immediates
  assign immSpn = {2'b00, cInst[10:7], cInst[12:11], cInst[5], cInst[6], 2'b00};
  assign immMem = {5'b00000, cInst[5], cInst[12:10], cInst[6], 2'b00};
  assign immCi  = {{7{cInst[12]}}, cInst[6:2]};
  assign immLui = {{15{cInst[12]}}, cInst[6:2]};
  assign immB   = {{5{cInst[12]}}, cInst[6:5], cInst[2], cInst[11:10], cInst[4:3], 1'b0};

  always_comb begin
    instr  = bundle.raw;    // Raw parcel unless expanded
    status = esUnsupported;
    if (!bundle.isCompressed) begin
      status = esFull;
    end else begin
      case (quad)
        qdZero: begin
          case (funct3)
            3'b000: begin
              if (cInst == '0) begin
                status = esIllegal;
              end else begin  // C.ADDI4SPN
                instr  = {immSpn, 5'd2, 3'b000, rs2Prime, opOpImm};
                status = esExpanded;
              end
            end
            3'b010: begin  // C.LW
              instr  = {immMem, rs1Prime, 3'b010, rs2Prime, opLoad};
              status = esExpanded;
            end
            3'b100: status = esIllegal;
            3'b110: begin  // C.SW
              instr  = {immMem[11:5], rs2Prime, rs1Prime, 3'b010, immMem[4:0], opStore};
              status = esExpanded;
            end
            default: status = esUnsupported;
          endcase
        end

        qdOne: begin
          case (funct3)
            3'b000: begin  // C.ADDI, C.NOP
              instr  = {immCi, rdFull, 3'b000, rdFull, opOpImm};
              status = esExpanded;
            end
            3'b010: begin  // C.LI
              instr  = {immCi, 5'd0, 3'b000, rdFull, opOpImm};
              status = esExpanded;
            end
            3'b011: begin
              if (rdFull != 5'd2) begin  // C.LUI, sp form left out
                instr  = {immLui, rdFull, opLui};
                status = esExpanded;
              end
            end
            3'b100: begin
              case (cInst[11:10])
                2'b10: begin  // C.ANDI
                  instr  = {immCi, rs1Prime, 3'b111, rs1Prime, opOpImm};
                  status = esExpanded;
                end
                2'b11: begin
                  status = esExpanded;
                  case ({cInst[12], cInst[6:5]})
                    3'b000: instr = {7'b0100000, rs2Prime, rs1Prime, 3'b000, rs1Prime, opOp};
                    3'b001: instr = {7'b0000000, rs2Prime, rs1Prime, 3'b100, rs1Prime, opOp};
                    3'b010: instr = {7'b0000000, rs2Prime, rs1Prime, 3'b110, rs1Prime, opOp};
                    3'b011: instr = {7'b0000000, rs2Prime, rs1Prime, 3'b111, rs1Prime, opOp};
                    3'b110, 3'b111: status = esIllegal;  // Reserved
                    default: status = esUnsupported;     // SUBW, ADDW
                  endcase
                end
                default: status = esUnsupported;  // Shifts
              endcase
            end
            3'b110: begin  // C.BEQZ
              instr  = {immB[12], immB[10:5], 5'd0, rs1Prime, 3'b000,
                        immB[4:1], immB[11], opBranch};
              status = esExpanded;
            end
            default: status = esUnsupported;
          endcase
        end

        qdTwo: begin
          if (funct3 == 3'b100 && cInst[12] && rs2Full != '0) begin  // C.ADD
            instr  = {7'b0000000, rs2Full, rdFull, 3'b000, rdFull, opOp};
            status = esExpanded;
          end
        end

        default: status = esUnsupported;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/expandStage.sv
`timescale 1ns/1ps
`default_nettype none

module expandStage (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 empty,
  input  rvcPkg::fetchBundle   headBundle,
  output logic                 pop,
  output logic                 instReq,
  input  logic                 instAck,
  output rvcPkg::expandedInstr instOut
);
  import rvcPkg::*;

  typedef enum logic [1:0] {
    osIdle,
    osReq,
    osRelease
  } outState;

  outState         state;
  logic [xlen-1:0] expInstr;
  expandStatus     expStatus;

  rvcExpander u_rvcExpander (
    .bundle (headBundle),
    .instr  (expInstr),
    .status (expStatus)
  );

  assign pop = (state == osIdle) && !empty;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state   <= osIdle;
      instReq <= 1'b0;
    end else begin
      case (state)
        osIdle: begin
          if (!empty) begin
            state <= osReq;
          end
        end
        osReq: begin
          if (!instReq) begin
            instReq <= 1'b1;  // instOut settled one cycle earlier
          end else if (instAck) begin
            instReq <= 1'b0;
            state   <= osRelease;
          end
        end
        osRelease: begin
          if (!instAck) begin
            state <= osIdle;
          end
        end
        default: state <= osIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      instOut <= '{pc: headBundle.pc, instr: expInstr, status: expStatus};
    end
  end

endmodule

`default_nettype wire

// File: logic/rvcFrontEnd.sv
`timescale 1ns/1ps
`default_nettype none

module rvcFrontEnd #(
  parameter logic [rvcPkg::xlen-1:0] resetPc    = 32'h0000_1000,
  parameter int unsigned             queueDepth = 4
) (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       parcelReq,
  input  logic [rvcPkg::parcelW-1:0] parcelData,
  output logic                       parcelAck,
  output logic                       instReq,
  input  logic                       instAck,
  output rvcPkg::expandedInstr       instOut
);
  import rvcPkg::*;

  logic       push;
  logic       full;
  logic       pop;
  logic       empty;
  fetchBundle pushBundle;
  fetchBundle headBundle;

  parcelAssembler #(
    .resetPc (resetPc)
  ) u_parcelAssembler (
    .clk        (clk),
    .rstN       (rstN),
    .parcelReq  (parcelReq),
    .parcelData (parcelData),
    .parcelAck  (parcelAck),
    .push       (push),
    .pushBundle (pushBundle),
    .full       (full)
  );

  fetchQueue #(
    .queueDepth (queueDepth)
  ) u_fetchQueue (
    .clk        (clk),
    .rstN       (rstN),
    .push       (push),
    .pushBundle (pushBundle),
    .full       (full),
    .pop        (pop),
    .headBundle (headBundle),
    .empty      (empty)
  );

  expandStage u_expandStage (
    .clk        (clk),
    .rstN       (rstN),
    .empty      (empty),
    .headBundle (headBundle),
    .pop        (pop),
    .instReq    (instReq),
    .instAck    (instAck),
    .instOut    (instOut)
  );

endmodule

`default_nettype wire

// File: verif/tbChecker.sv
`timescale 1ns/1ps
`default_nettype none

module tbChecker #(
  parameter logic [rvcPkg::xlen-1:0] resetPc = '0
) (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       parcelReq,
  input  logic [rvcPkg::parcelW-1:0] parcelData,
  input  logic                       parcelAck,
  input  logic                       instReq,
  input  logic                       instAck,
  input  rvcPkg::expandedInstr       instOut,
  output int                         outCount
);
  import rvcPkg::*;

  expandedInstr       expQ [$];   // Expected results in order
  expandedInstr       expected;
  expandedInstr       lastOut;
  logic [xlen-1:0]    pcModel;
  logic [parcelW-1:0] lowParcel;
  logic               haveLow;
  logic               prevParcelAck;
  logic               prevReq;
  logic               prevAck;
  int                 inCount;
  int                 valueErrors;
  int                 protoErrors;
  int                 countErrors;

  function automatic logic [31:0] iType(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] rType(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return iType({f7, rs2}, rs1, f3, rd, 7'b0110011);
  endfunction

  // Standard RV32C expansion, limited to the supported subset
  function automatic expandedInstr refExpand(logic [31:0] pc, logic [31:0] raw);
    expandedInstr e;
    logic [15:0]  c;
    logic [4:0]   rd;
    logic [4:0]   rdp;
    logic [4:0]   rs1p;
    logic [11:0]  imm6;
    logic [11:0]  memOff;
    logic [12:0]  br;
    c      = raw[15:0];
    rd     = c[11:7];
    rdp    = {2'b01, c[4:2]};  // rd' or rs2'
    rs1p   = {2'b01, c[9:7]};
    imm6   = {{6{c[12]}}, c[12], c[6:2]};
    memOff = {5'd0, c[5], c[12:10], c[6], 2'b00};
    br     = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    e.pc     = pc;
    e.instr  = {16'd0, c};
    e.status = esExpanded;
    if (raw[1:0] == 2'b11) begin
      e.instr  = raw;
      e.status = esFull;
    end else if (c == 16'd0) begin
      e.status = esIllegal;
    end else begin
      case ({c[15:13], c[1:0]})
        5'b000_00: e.instr = iType({2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00}, 5'd2,
                                   3'b000, rdp, 7'b0010011);  // C.ADDI4SPN
        5'b010_00: e.instr = iType(memOff, rs1p, 3'b010, rdp, 7'b0000011);
        5'b110_00: e.instr = {memOff[11:5], rdp, rs1p, 3'b010, memOff[4:0], 7'b0100011};
        5'b100_00: e.status = esIllegal;
        5'b000_01: e.instr = iType(imm6, rd, 3'b000, rd, 7'b0010011);
        5'b010_01: e.instr = iType(imm6, 5'd0, 3'b000, rd, 7'b0010011);
        5'b011_01: begin
          if (rd == 5'd2) e.status = esUnsupported;  // C.ADDI16SP
          else e.instr = {{8{imm6[11]}}, imm6, rd, 7'b0110111};
        end
        5'b100_01: begin
          if (c[11:10] == 2'b10) e.instr = iType(imm6, rs1p, 3'b111, rs1p, 7'b0010011);
          else if (c[11:10] != 2'b11) e.status = esUnsupported;  // Shifts
          else if (c[12]) e.status = c[6] ? esIllegal : esUnsupported;
          else begin
            case (c[6:5])
              2'b00: e.instr = rType(7'b0100000, rdp, rs1p, 3'b000, rs1p);
              2'b01: e.instr = rType(7'b0000000, rdp, rs1p, 3'b100, rs1p);
              2'b10: e.instr = rType(7'b0000000, rdp, rs1p, 3'b110, rs1p);
              default: e.instr = rType(7'b0000000, rdp, rs1p, 3'b111, rs1p);
            endcase
          end
        end
        5'b110_01: e.instr = {br[12], br[10:5], 5'd0, rs1p, 3'b000, br[4:1], br[11], 7'b1100011};
        5'b100_10: begin
          if (c[12] && c[6:2] != 5'd0) e.instr = rType(7'd0, c[6:2], rd, 3'b000, rd);
          else e.status = esUnsupported;  // MV, JR, JALR, EBREAK
        end
        default: e.status = esUnsupported;
      endcase
    end
    return e;
  endfunction

  always @(posedge clk) begin
    if (!rstN) begin
      if (parcelAck || instReq) begin
        protoErrors++;
        $display("parcelAck or instReq high during reset at %0t", $time);
      end
      pcModel       = resetPc;
      haveLow       = 1'b0;
      prevParcelAck = 1'b0;
      prevReq       = 1'b0;
      prevAck       = 1'b0;
      outCount      = 0;
    end else begin
      if (parcelAck && !prevParcelAck) begin
        if (!parcelReq) begin
          protoErrors++;
          $display("parcelAck rose without parcelReq at %0t", $time);
        end
        if (haveLow) begin  // Upper half of a full word
          expQ.push_back(refExpand(pcModel, {parcelData, lowParcel}));
          pcModel = pcModel + 32'd4;
          haveLow = 1'b0;
          inCount++;
        end else if (parcelData[1:0] == 2'b11) begin
          lowParcel = parcelData;
          haveLow   = 1'b1;
        end else begin
          expQ.push_back(refExpand(pcModel, {16'd0, parcelData}));
          pcModel = pcModel + 32'd2;
          inCount++;
        end
      end
      if (instReq && !prevReq) begin
        outCount++;
        if (prevAck) begin  // Ack level the DUT saw when it raised instReq
          protoErrors++;
          $display("instReq rose again while instAck was still high at %0t", $time);
        end
        if (expQ.size() == 0) begin
          valueErrors++;
          $display("Fail %0t: output pc %h with no instruction pending", $time, instOut.pc);
        end else begin
          expected = expQ.pop_front();
          if (instOut !== expected) begin
            valueErrors++;
            $display("Fail %0t: got pc %h instr %h %s, expected pc %h instr %h %s", $time,
                     instOut.pc, instOut.instr, instOut.status.name(),
                     expected.pc, expected.instr, expected.status.name());
          end
        end
      end
      if (prevReq && !instReq && !prevAck) begin
        protoErrors++;
        $display("instReq dropped before instAck was high at %0t", $time);
      end
      if (prevReq && instReq && !prevAck && instOut !== lastOut) begin
        protoErrors++;
        $display("instOut changed while waiting for instAck at %0t", $time);
      end
      prevParcelAck = parcelAck;
      prevReq       = instReq;
      prevAck       = instAck;
      lastOut       = instOut;
    end
  end

  task automatic finalReport(output int total);
    if (expQ.size() != 0 || inCount != outCount) begin
      countErrors++;
      $display("Instruction count mismatch: %0d in, %0d out, %0d never came out",
               inCount, outCount, expQ.size());
    end
    $display("Checked %0d instructions: %0d value errors, %0d protocol errors, %0d count errors",
             outCount, valueErrors, protoErrors, countErrors);
    total = valueErrors + protoErrors + countErrors;
  endtask

endmodule

`default_nettype wire

// File: verif/tbTop.sv
`timescale 1ns/1ps
`default_nettype none

module tbTop;
  import rvcPkg::*;

  localparam logic [xlen-1:0] resetPc    = 32'h0000_1000;
  localparam int unsigned     queueDepth = 4;
  localparam int              numInstr   = 400;
  // {funct3, quadrant} of the supported compressed forms
  localparam logic [8:0][4:0] supportedKeys = {5'b100_10, 5'b110_01, 5'b100_01, 5'b011_01,
                                               5'b010_01, 5'b000_01, 5'b110_00, 5'b010_00,
                                               5'b000_00};

  logic               clk = 1'b0;
  logic               rstN;
  logic               parcelReq;
  logic [parcelW-1:0] parcelData;
  logic               parcelAck;
  logic               instReq;
  logic               instAck;
  expandedInstr       instOut;
  int                 outCount;
  int                 errTotal;
  logic [xlen-1:0]    word;

  always #5 clk = ~clk;

  rvcFrontEnd #(
    .resetPc    (resetPc),
    .queueDepth (queueDepth)
  ) u_rvcFrontEnd (
    .clk        (clk),
    .rstN       (rstN),
    .parcelReq  (parcelReq),
    .parcelData (parcelData),
    .parcelAck  (parcelAck),
    .instReq    (instReq),
    .instAck    (instAck),
    .instOut    (instOut)
  );

  tbChecker #(
    .resetPc (resetPc)
  ) u_tbChecker (
    .clk        (clk),
    .rstN       (rstN),
    .parcelReq  (parcelReq),
    .parcelData (parcelData),
    .parcelAck  (parcelAck),
    .instReq    (instReq),
    .instAck    (instAck),
    .instOut    (instOut),
    .outCount   (outCount)
  );

  // Full words, zero parcels, steered supported forms, fully random compressed codes
  function automatic logic [xlen-1:0] randomInstr();
    logic [xlen-1:0] w;
    logic [4:0]      key;
    int unsigned     pick;
    w    = $urandom;
    pick = $urandom % 16;
    key  = supportedKeys[4'($urandom % 9)];
    if (pick < 4) begin
      w[1:0] = 2'b11;
    end else begin
      w[xlen-1:16] = '0;
      w[1:0]       = 2'($urandom % 3);
      if (pick == 4) w = '0;
      else if (pick < 13) {w[15:13], w[1:0]} = key;
    end
    return w;
  endfunction

  task automatic sendParcel(input logic [parcelW-1:0] parcel);
    repeat ($urandom % 4) @(posedge clk);  // Idle gap
    parcelData <= parcel;
    parcelReq  <= 1'b1;
    do @(negedge clk); while (!parcelAck);
    @(posedge clk);
    parcelReq <= 1'b0;
    do @(negedge clk); while (parcelAck);
    @(posedge clk);
  endtask

  initial begin
    void'($urandom(32'hd257d815));
    rstN       = 1'b0;
    parcelReq  = 1'b0;
    parcelData = '0;
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    for (int i = 0; i < numInstr; i++) begin
      word = randomInstr();
      sendParcel(word[15:0]);
      if (word[1:0] == 2'b11) sendParcel(word[31:16]);
    end
    while (outCount < numInstr) @(posedge clk);
    repeat (20) @(posedge clk);  // Room for stray outputs
    u_tbChecker.finalReport(errTotal);
    if (errTotal == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Output side, 12 cycle stalls back the queue up
  initial begin
    int unsigned delay;
    instAck = 1'b0;
    @(posedge rstN);
    forever begin
      do @(negedge clk); while (!instReq);
      delay = ($urandom % 4 == 0) ? 12 : $urandom % 4;
      repeat (delay) @(posedge clk);
      @(posedge clk);
      instAck <= 1'b1;
      do @(negedge clk); while (instReq);
      repeat ($urandom % 3) @(posedge clk);  // Late release
      @(posedge clk);
      instAck <= 1'b0;
    end
  end

  initial begin
    repeat (numInstr * 30 + 1000) @(posedge clk);
    $display("Timeout: not all instructions came out within %0d cycles", numInstr * 30 + 1000);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
logic/rvcPkg.sv
logic/parcelAssembler.sv
logic/fetchQueue.sv
logic/rvcExpander.sv
logic/expandStage.sv
logic/rvcFrontEnd.sv
verif/tbChecker.sv
verif/tbTop.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tbTop -o simv
./obj_dir/simv | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"
